/* project.f */
kernelPkg.sv
axiPkg.sv
paramFetcher.sv
kernelControl.sv
resultWriter.sv
hostLoopback.sv
kernelTop.sv
kernelChecker.sv
kernelTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the kernel testbench with Verilator, run it and look for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module kernelTb -o kernelSim

output="$(./obj_dir/kernelSim)"
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

/* kernelTb.sv */
// Testbench top with clock, reset, run sequence and parameter file, engine and memory models.
`timescale 1ns/1ps

module kernelTb;

  localparam int numRuns = 20;
  localparam int runBudget = 400;
  localparam int resetCycles = 16;
  localparam int expectedTests = 2 + 3 * numRuns;
  localparam int watchdogNs = (resetCycles + numRuns * runBudget) * 10;

  logic                   clk;
  logic                   reset;
  logic                   goReady;
  logic                   goStop;
  logic                   doneReady;
  logic                   doneStop;
  logic                   paramAddrReady;
  logic [31:0]            paramAddrData;
  logic                   paramAddrStop = 1'b1;
  logic                   paramDataReady = 1'b0;
  logic [31:0]            paramDataData = 32'd0;
  logic                   paramDataStop;
  logic                   testConfigValid;
  kernelPkg::testConfig_t testConfig;
  logic                   testConfigStop = 1'b1;
  logic                   testStatusValid = 1'b0;
  kernelPkg::testStatus_t testStatus = '0;
  logic                   testStatusStop;
  axiPkg::writeAddr_t     writeAddr;
  logic                   awValid;
  logic                   awReady = 1'b0;
  axiPkg::writeData_t     writeData;
  logic                   wValid;
  logic                   wReady = 1'b0;
  axiPkg::axiResp_t       bResp = axiPkg::Okay;
  logic                   bValid = 1'b0;
  logic                   bReady;
  logic [31:0]            hostArAddr;
  logic                   hostArValid;
  logic                   hostArReady;
  logic [31:0]            hostRData;
  axiPkg::axiResp_t       hostRResp;
  logic                   hostRValid;
  logic                   hostRReady;
  logic [31:0]            hostAwAddr;
  logic                   hostAwValid;
  logic                   hostAwReady;
  logic [31:0]            hostWData;
  logic                   hostWValid;
  logic                   hostWReady;
  axiPkg::axiResp_t       hostBResp;
  logic                   hostBValid;
  logic                   hostBReady;
  int                     errorTotal;
  int                     testTotal;

  // Model state.
  integer      seed = 51;
  logic [31:0] wordQueue [$];
  logic        dataFired = 1'b0;
  logic        statusFired = 1'b0;
  int          statusWait = 0;
  logic        awGot = 1'b0;
  logic        wGot = 1'b0;
  logic        bFired = 1'b0;

  kernelTop DUT (.*);

  kernelChecker check (.*);

  always #5 clk = ~clk;

  function automatic logic chance(int percent);
    return ($unsigned($random(seed)) % 100) < percent;
  endfunction

  // Each model decides its inputs, then notes what transfers on the next rising edge.
  always @(negedge clk)
  begin
    if (!reset)
    begin
      // Parameter file returns one random word per accepted offset, in order.
      if (dataFired)
        paramDataReady = 1'b0;
      if (!paramDataReady && wordQueue.size() > 0 && chance(70))
      begin
        paramDataReady = 1'b1;
        paramDataData = wordQueue.pop_front();
      end
      dataFired = paramDataReady && !paramDataStop;
      paramAddrStop = chance(30);
      if (paramAddrReady && !paramAddrStop)
        wordQueue.push_back($random(seed));

      // Test engine answers each configuration after a random delay.
      if (statusFired)
        testStatusValid = 1'b0;
      if (statusWait > 0)
      begin
        statusWait = statusWait - 1;
        if (statusWait == 0)
        begin
          testStatusValid = 1'b1;
          testStatus.errorCount = $random(seed);
          testStatus.dataCount = {$random(seed), $random(seed)};
        end
      end
      statusFired = testStatusValid && !testStatusStop;
      testConfigStop = chance(30);
      if (testConfigValid && !testConfigStop)
        statusWait = 1 + int'($unsigned($random(seed)) % 16);

      // Memory slave responds once both address and data are in.
      if (bFired)
        bValid = 1'b0;
      if (awGot && wGot && chance(60))
      begin
        bValid = 1'b1;
        awGot = 1'b0;
        wGot = 1'b0;
      end
      bFired = bValid && bReady;
      awReady = chance(60);
      wReady = chance(60);
      if (awValid && awReady)
        awGot = 1'b1;
      if (wValid && wReady)
        wGot = 1'b1;
    end
  end

  task automatic startRun();
    logic accepted;
    repeat ($unsigned($random(seed)) % 4)
      @(negedge clk);
    goReady = 1'b1;
    accepted = !goStop;
    while (!accepted)
    begin
      @(negedge clk);
      accepted = !goStop;
    end
    @(negedge clk);
    goReady = 1'b0;
  endtask

  task automatic awaitDone();
    logic taken;
    taken = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      doneStop = chance(30);
      // Early go requests that the kernel has to hold off.
      goReady = chance(50);
      taken = doneReady && !doneStop;
    end
    @(negedge clk);
    doneStop = 1'b1;
    goReady = 1'b0;
  endtask

  task automatic hostRead();
    logic taken;
    hostArAddr = $random(seed);
    hostArValid = 1'b1;
    while (!hostArReady)
    begin
      @(negedge clk);
    end
    taken = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      hostArValid = 1'b0;
      hostRReady = chance(60);
      taken = hostRValid && hostRReady;
    end
    @(negedge clk);
    hostRReady = 1'b0;
  endtask

  task automatic hostWrite();
    logic taken;
    hostAwAddr = $random(seed);
    hostWData = $random(seed);
    hostAwValid = 1'b1;
    hostWValid = 1'b1;
    while (!hostAwReady)
    begin
      @(negedge clk);
    end
    taken = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      hostAwValid = 1'b0;
      hostWValid = 1'b0;
      hostBReady = chance(60);
      taken = hostBValid && hostBReady;
    end
    @(negedge clk);
    hostBReady = 1'b0;
  endtask

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    goReady = 1'b0;
    doneStop = 1'b1;
    hostArAddr = 32'd0;
    hostArValid = 1'b0;
    hostRReady = 1'b0;
    hostAwAddr = 32'd0;
    hostAwValid = 1'b0;
    hostWData = 32'd0;
    hostWValid = 1'b0;
    hostBReady = 1'b0;
    repeat (resetCycles)
      @(negedge clk);
    reset = 1'b0;
    // A read before the first run sees the reset value of the error count.
    hostRead();
    // Host traffic goes between runs, while the kernel sits in Idle.
    for (int run = 0; run < numRuns; run++)
    begin
      startRun();
      awaitDone();
      hostRead();
      hostWrite();
    end
    @(negedge clk);
    $display("Tests completed: %0d of %0d, errors: %0d", testTotal, expectedTests, errorTotal);
    if (errorTotal == 0 && testTotal == expectedTests)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial
  begin
    #(watchdogNs);
    $display("Simulation timed out after %0d ns before all runs finished", watchdogNs);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* kernelChecker.sv */
// Kernel checker that watches the DUT ports, compares transfers and counts tests.
`timescale 1ns/1ps

module kernelChecker
  (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   goReady, goStop, doneReady, doneStop,
  input  logic                   paramAddrReady, paramAddrStop,
  input  logic [31:0]            paramAddrData,
  input  logic                   paramDataReady, paramDataStop,
  input  logic [31:0]            paramDataData,
  input  logic                   testConfigValid, testConfigStop,
  input  kernelPkg::testConfig_t testConfig,
  input  logic                   testStatusValid, testStatusStop,
  input  kernelPkg::testStatus_t testStatus,
  input  axiPkg::writeAddr_t     writeAddr,
  input  axiPkg::writeData_t     writeData,
  input  logic                   awValid, awReady, wValid, wReady, bValid, bReady,
  input  logic                   hostArReady, hostRValid, hostRReady,
  input  logic [31:0]            hostRData,
  input  axiPkg::axiResp_t       hostRResp,
  input  logic                   hostAwReady, hostWReady, hostBValid, hostBReady,
  input  axiPkg::axiResp_t       hostBResp,
  output int                     errorTotal,
  output int                     testTotal
  );

  logic [31:0] words [8];
  logic [31:0] expErr;
  logic [63:0] expDcount;
  logic [31:0] lastErr;
  logic        goStopFell;
  logic        runActive;
  int          sinceReset;
  int          runIdx;
  int          testErrors;
  int          addrCount;
  int          dataIdx;
  int          configCount;
  int          awCount;
  int          wCount;
  int          bCount;

  task automatic reportMismatch(string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    errorTotal++;
    testErrors++;
  endtask

  task automatic closeTest(string name);
    $display("Test %s: %s", name, (testErrors == 0) ? "ok" : "FAILED");
    testTotal++;
    testErrors = 0;
  endtask

  // Idle levels right after reset, and goStop dropping once Idle is reached.
  task automatic checkStartup();
    if (sinceReset == 0)
    begin
      if (doneReady || paramAddrReady || testConfigValid || awValid || wValid || bReady)
        reportMismatch("kernel handshake outputs not low after reset");
      if (hostArReady || hostRValid || hostAwReady || hostWReady || hostBValid)
        reportMismatch("host outputs not low after reset");
      if (!paramDataStop || !testStatusStop)
        reportMismatch("paramDataStop or testStatusStop not high after reset");
    end
    if (!goStop)
      goStopFell = 1'b1;
    if (sinceReset == 2)
    begin
      if (!goStopFell)
        reportMismatch("goStop did not fall within two cycles of reset");
      closeTest("reset");
    end
    if (sinceReset < 3)
      sinceReset++;
  endtask

  task automatic checkRunTraffic();
    logic [63:0] expAddr;
    logic [63:0] expData;
    if (goReady && !goStop)
    begin
      if (runActive)
        reportMismatch("go accepted before the previous done transfer");
      runActive = 1'b1;
      addrCount = 0;
      dataIdx = 0;
      configCount = 0;
      awCount = 0;
      wCount = 0;
      bCount = 0;
    end
    // Offsets run from 0x40 in steps of one word.
    if (paramAddrReady && !paramAddrStop)
    begin
      if (addrCount >= 8 || paramAddrData != 32'h40 + 4 * addrCount)
        reportMismatch($sformatf("parameter address %0d is %h, expected %h",
                                 addrCount, paramAddrData, 32'h40 + 4 * addrCount));
      addrCount++;
    end
    if (paramDataReady && !paramDataStop)
    begin
      if (dataIdx < 8)
        words[dataIdx] = paramDataData;
      else
        reportMismatch("more than eight parameter words accepted");
      dataIdx++;
    end
    if (testConfigValid && !testConfigStop)
    begin
      configCount++;
      if (dataIdx != 8)
        reportMismatch("configuration offered before all parameter words arrived");
      if (testConfig.memBaseAddr != {words[1], words[0]})
        reportMismatch($sformatf("base address %h, expected %h",
                                 testConfig.memBaseAddr, {words[1], words[0]}));
      if (testConfig.memBlockLength != words[2] || testConfig.testCount != words[3])
        reportMismatch($sformatf("length %h count %h, expected %h and %h",
                                 testConfig.memBlockLength, testConfig.testCount,
                                 words[2], words[3]));
    end
    if (testStatusValid && !testStatusStop)
    begin
      expErr = testStatus.errorCount;
      expDcount = testStatus.dataCount;
    end
    // First write carries the error count, second one the data count.
    if (awValid && awReady)
    begin
      expAddr = (awCount == 0) ? {words[5], words[4]} : {words[7], words[6]};
      if (writeAddr.addr != expAddr || writeAddr.len != 8'd0 || writeAddr.size != 3'd3 ||
          writeAddr.cache != 4'd3)
        reportMismatch($sformatf("write %0d to %h len %0d size %0d cache %0d, expected %h",
                                 awCount, writeAddr.addr, writeAddr.len, writeAddr.size,
                                 writeAddr.cache, expAddr));
      awCount++;
    end
    if (wValid && wReady)
    begin
      expData = (wCount == 0) ? {32'd0, expErr} : expDcount;
      if (writeData.data != expData || writeData.strb != 8'hFF || !writeData.last)
        reportMismatch($sformatf("write %0d data %h strb %h last %b, expected %h strb ff last 1",
                                 wCount, writeData.data, writeData.strb, writeData.last,
                                 expData));
      wCount++;
    end
    if (bValid && bReady)
      bCount++;
    if (doneReady && !doneStop)
    begin
      if (!runActive || addrCount != 8 || configCount != 1)
        reportMismatch($sformatf("done with %0d addresses and %0d configurations",
                                 addrCount, configCount));
      if (awCount != 2 || wCount != 2 || bCount != 2)
        reportMismatch($sformatf("done after %0d/%0d/%0d aw/w/b transfers, expected 2 each",
                                 awCount, wCount, bCount));
      lastErr = expErr;
      runActive = 1'b0;
      closeTest($sformatf("run %0d", runIdx));
      runIdx++;
    end
  endtask

  task automatic checkHost();
    if (hostRValid && hostRReady)
    begin
      if (hostRData != lastErr || hostRResp != axiPkg::Okay)
        reportMismatch($sformatf("host read returned %h resp %0d, expected %h resp 0",
                                 hostRData, hostRResp, lastErr));
      closeTest($sformatf("host read %0d", runIdx));
    end
    if (hostBValid && hostBReady)
    begin
      if (hostBResp != axiPkg::Okay)
        reportMismatch($sformatf("host write resp %0d, expected 0", hostBResp));
      closeTest($sformatf("host write %0d", runIdx));
    end
  endtask

  always @(posedge clk)
  begin
    if (reset)
    begin
      sinceReset = 0;
      goStopFell = 1'b0;
      runActive = 1'b0;
      runIdx = 0;
      lastErr = 32'd0;
      testErrors = 0;
      errorTotal = 0;
      testTotal = 0;
    end
    else
    begin
      checkStartup();
      checkRunTraffic();
      checkHost();
    end
  end

endmodule

/* kernelTop.sv */
// Kernel top level connecting control, parameter fetch, result writer and host slave.
`timescale 1ns/1ps

module kernelTop
  (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   goReady,
  output logic                   goStop,
  output logic                   doneReady,
  input  logic                   doneStop,
  output logic                   paramAddrReady,
  output logic [31:0]            paramAddrData,
  input  logic                   paramAddrStop,
  input  logic                   paramDataReady,
  input  logic [31:0]            paramDataData,
  output logic                   paramDataStop,
  output logic                   testConfigValid,
  output kernelPkg::testConfig_t testConfig,
  input  logic                   testConfigStop,
  input  logic                   testStatusValid,
  input  kernelPkg::testStatus_t testStatus,
  output logic                   testStatusStop,
  output axiPkg::writeAddr_t     writeAddr,
  output logic                   awValid,
  input  logic                   awReady,
  output axiPkg::writeData_t     writeData,
  output logic                   wValid,
  input  logic                   wReady,
  input  axiPkg::axiResp_t       bResp,
  input  logic                   bValid,
  output logic                   bReady,
  input  logic [31:0]            hostArAddr,
  input  logic                   hostArValid,
  output logic                   hostArReady,
  output logic [31:0]            hostRData,
  output axiPkg::axiResp_t       hostRResp,
  output logic                   hostRValid,
  input  logic                   hostRReady,
  input  logic [31:0]            hostAwAddr,
  input  logic                   hostAwValid,
  output logic                   hostAwReady,
  input  logic [31:0]            hostWData,
  input  logic                   hostWValid,
  output logic                   hostWReady,
  output axiPkg::axiResp_t       hostBResp,
  output logic                   hostBValid,
  input  logic                   hostBReady
  );

  logic                         fetchStart;
  logic                         paramsDone;
  kernelPkg::kernelParams_t     params;
  logic                         writeReqValid;
  logic [axiPkg::addrWidth-1:0] writeReqAddr;
  logic [axiPkg::dataWidth-1:0] writeReqData;
  logic                         writeReqStop;
  logic                         writeDone;
  logic [31:0]                  errorCount;

  kernelControl control
    (.clk, .reset, .goReady, .goStop, .doneReady, .doneStop,
     .fetchStart, .paramsDone, .params,
     .testConfigValid, .testConfig, .testConfigStop,
     .testStatusValid, .testStatus, .testStatusStop,
     .writeReqValid, .writeReqAddr, .writeReqData, .writeReqStop, .writeDone,
     .errorCount);

  paramFetcher fetcher
    (.clk, .reset, .fetchStart,
     .paramAddrReady, .paramAddrData, .paramAddrStop,
     .paramDataReady, .paramDataData, .paramDataStop,
     .paramsDone, .params);

  // Single memory master, so the writer owns the AXI write channels.
  resultWriter writer
    (.clk, .reset, .writeReqValid, .writeReqAddr, .writeReqData, .writeReqStop, .writeDone,
     .writeAddr, .awValid, .awReady, .writeData, .wValid, .wReady,
     .bResp, .bValid, .bReady);

  hostLoopback host
    (.clk, .reset, .errorCount,
     .hostArAddr, .hostArValid, .hostArReady,
     .hostRData, .hostRResp, .hostRValid, .hostRReady,
     .hostAwAddr, .hostAwValid, .hostAwReady,
     .hostWData, .hostWValid, .hostWReady,
     .hostBResp, .hostBValid, .hostBReady);

endmodule

/* hostLoopback.sv */
// Host AXI-lite slave answering reads with the error count and ignoring writes.
`timescale 1ns/1ps

module hostLoopback
  (
  input  logic             clk,
  input  logic             reset,
  input  logic [31:0]      errorCount,
  input  logic [31:0]      hostArAddr,
  input  logic             hostArValid,
  output logic             hostArReady,
  output logic [31:0]      hostRData,
  output axiPkg::axiResp_t hostRResp,
  output logic             hostRValid,
  input  logic             hostRReady,
  input  logic [31:0]      hostAwAddr,
  input  logic             hostAwValid,
  output logic             hostAwReady,
  input  logic [31:0]      hostWData,
  input  logic             hostWValid,
  output logic             hostWReady,
  output axiPkg::axiResp_t hostBResp,
  output logic             hostBValid,
  input  logic             hostBReady
  );

  typedef enum logic [1:0] {LoopIdle, LoopAccept, LoopRespond} loopState_t;

  loopState_t readState;
  loopState_t writeState;

  // Shared step for both loopbacks: accept for one cycle, then respond.
  function automatic loopState_t loopNext(loopState_t cur, logic request, logic respTaken);
    case (cur)
      LoopIdle:
        return request ? LoopAccept : LoopIdle;
      LoopAccept:
        return LoopRespond;
      default:
        return respTaken ? LoopIdle : LoopRespond;
    endcase
  endfunction

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      readState <= LoopIdle;
      writeState <= LoopIdle;
    end
    else
    begin
      readState <= loopNext(readState, hostArValid, hostRReady);
      writeState <= loopNext(writeState, hostAwValid && hostWValid, hostBReady);
    end
  end

  // Addresses and write data carry no meaning here.
  assign hostArReady = (readState == LoopAccept);
  assign hostRValid = (readState == LoopRespond);
  assign hostRData = errorCount;
  assign hostRResp = axiPkg::Okay;

  assign hostAwReady = (writeState == LoopAccept);
  assign hostWReady = (writeState == LoopAccept);
  assign hostBValid = (writeState == LoopRespond);
  assign hostBResp = axiPkg::Okay;

endmodule

/* resultWriter.sv */
// Result writer performing one single-beat 64-bit AXI write per request.
`timescale 1ns/1ps

module resultWriter
  (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         writeReqValid,
  input  logic [axiPkg::addrWidth-1:0] writeReqAddr,
  input  logic [axiPkg::dataWidth-1:0] writeReqData,
  output logic                         writeReqStop,
  output logic                         writeDone,
  output axiPkg::writeAddr_t           writeAddr,
  output logic                         awValid,
  input  logic                         awReady,
  output axiPkg::writeData_t           writeData,
  output logic                         wValid,
  input  logic                         wReady,
  input  axiPkg::axiResp_t             bResp,
  input  logic                         bValid,
  output logic                         bReady
  );

  typedef enum logic [1:0] {WriterIdle, WriterSend, WriterResp} writerState_t;

  writerState_t                 state;
  logic [axiPkg::addrWidth-1:0] addrReg;
  logic [axiPkg::dataWidth-1:0] dataReg;
  logic                         awPending;
  logic                         wPending;

  assign awPending = awValid && !awReady;
  assign wPending = wValid && !wReady;
  assign writeReqStop = (state != WriterIdle);
  assign bReady = (state == WriterResp);

  assign writeAddr = '{addr: addrReg, len: axiPkg::writeLen,
                       size: axiPkg::writeSize, cache: axiPkg::writeCache};
  assign writeData = '{data: dataReg, strb: axiPkg::writeStrb, last: 1'b1};

  // Address and data handshakes complete in any order.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= WriterIdle;
      awValid <= 1'b0;
      wValid <= 1'b0;
      writeDone <= 1'b0;
    end
    else
    begin
      writeDone <= 1'b0;
      case (state)
        WriterIdle:
        begin
          if (writeReqValid)
          begin
            state <= WriterSend;
            awValid <= 1'b1;
            wValid <= 1'b1;
          end
        end
        WriterSend:
        begin
          awValid <= awPending;
          wValid <= wPending;
          if (!awPending && !wPending)
            state <= WriterResp;
        end
        default:
        begin
          // response code is taken but not acted on.
          if (bValid)
          begin
            state <= WriterIdle;
            writeDone <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == WriterIdle && writeReqValid)
    begin
      addrReg <= writeReqAddr;
      dataReg <= writeReqData;
    end
  end

  // The address beat is held until the slave takes it.
  assert property (@(posedge clk) disable iff (reset)
    awValid && !awReady |=> awValid && $stable(writeAddr));

endmodule

/* kernelControl.sv */
// Kernel control FSM sequencing fetch, test, result writes and done.
`timescale 1ns/1ps

module kernelControl
  (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          goReady,
  output logic                          goStop,
  output logic                          doneReady,
  input  logic                          doneStop,
  output logic                          fetchStart,
  input  logic                          paramsDone,
  input  kernelPkg::kernelParams_t      params,
  output logic                          testConfigValid,
  output kernelPkg::testConfig_t        testConfig,
  input  logic                          testConfigStop,
  input  logic                          testStatusValid,
  input  kernelPkg::testStatus_t        testStatus,
  output logic                          testStatusStop,
  output logic                          writeReqValid,
  output logic [axiPkg::addrWidth-1:0]  writeReqAddr,
  output logic [axiPkg::dataWidth-1:0]  writeReqData,
  input  logic                          writeReqStop,
  input  logic                          writeDone,
  output logic [31:0]                   errorCount
  );

  kernelPkg::runState_t state;
  kernelPkg::runState_t stateNext;
  logic [63:0]          dataCount;

  // Configuration is taken straight from the held parameters.
  assign testConfig = '{memBaseAddr: params.memBaseAddr,
                        memBlockLength: params.memBlockLength,
                        testCount: params.testCount};

  always_comb
  begin
    stateNext = state;
    goStop = 1'b1;
    doneReady = 1'b0;
    fetchStart = 1'b0;
    testConfigValid = 1'b0;
    testStatusStop = 1'b1;
    writeReqValid = 1'b0;
    writeReqAddr = params.errResultAddr;
    writeReqData = {32'd0, errorCount};
    case (state)
      kernelPkg::Idle:
      begin
        goStop = 1'b0;
        fetchStart = goReady;
        if (goReady)
          stateNext = kernelPkg::Fetch;
      end
      kernelPkg::Fetch:
      begin
        if (paramsDone)
          stateNext = kernelPkg::SetConfig;
      end
      kernelPkg::SetConfig:
      begin
        testConfigValid = 1'b1;
        if (!testConfigStop)
          stateNext = kernelPkg::GetStatus;
      end
      kernelPkg::GetStatus:
      begin
        testStatusStop = 1'b0;
        if (testStatusValid)
          stateNext = kernelPkg::WriteErr;
      end
      kernelPkg::WriteErr:
      begin
        writeReqValid = 1'b1;
        if (!writeReqStop)
          stateNext = kernelPkg::WaitErr;
      end
      kernelPkg::WaitErr:
      begin
        if (writeDone)
          stateNext = kernelPkg::WriteDcount;
      end
      kernelPkg::WriteDcount:
      begin
        writeReqValid = 1'b1;
        writeReqAddr = params.dcountResultAddr;
        writeReqData = dataCount;
        if (!writeReqStop)
          stateNext = kernelPkg::WaitDcount;
      end
      kernelPkg::WaitDcount:
      begin
        if (writeDone)
          stateNext = kernelPkg::Report;
      end
      kernelPkg::Report:
      begin
        doneReady = 1'b1;
        if (!doneStop)
          stateNext = kernelPkg::Idle;
      end
      default:
      begin
        stateNext = kernelPkg::Idle;
      end
    endcase
  end

  // Error count is visible to the host, so it starts at zero.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= kernelPkg::Reset;
      errorCount <= 32'd0;
    end
    else
    begin
      state <= stateNext;
      if (fetchStart)
        errorCount <= 32'd0;
      else if (!testStatusStop && testStatusValid)
        errorCount <= testStatus.errorCount;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!testStatusStop && testStatusValid)
      dataCount <= testStatus.dataCount;
  end

  // Done is only offered once the data count write has completed.
  assert property (@(posedge clk) disable iff (reset)
    $rose(doneReady) |-> $past(writeDone) && state == kernelPkg::Report);

  // A new go is only taken with no result write outstanding.
  assert property (@(posedge clk) disable iff (reset)
    !goStop |-> !writeReqStop);

endmodule

/* paramFetcher.sv */
// Parameter fetcher issuing register offsets and assembling the returned words.
`timescale 1ns/1ps

module paramFetcher
  (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    fetchStart,
  output logic                    paramAddrReady,
  output logic [31:0]             paramAddrData,
  input  logic                    paramAddrStop,
  input  logic                    paramDataReady,
  input  logic [31:0]             paramDataData,
  output logic                    paramDataStop,
  output logic                    paramsDone,
  output kernelPkg::kernelParams_t params
  );

  logic                                      addrActive;
  logic [kernelPkg::paramIdxWidth-1:0]       addrIdx;
  logic                                      dataActive;
  logic [kernelPkg::paramIdxWidth-1:0]       dataIdx;
  logic [kernelPkg::numParamWords-1:0][31:0] words;

  assign paramAddrReady = addrActive;
  assign paramAddrData = kernelPkg::paramOffsets[addrIdx];
  assign paramDataStop = ~dataActive;

  // Address side walks the offset table, one step per transfer.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      addrActive <= 1'b0;
      addrIdx <= '0;
    end
    else if (fetchStart)
    begin
      addrActive <= 1'b1;
      addrIdx <= '0;
    end
    else if (addrActive && !paramAddrStop)
    begin
      addrIdx <= addrIdx + 1'b1;
      if (addrIdx == kernelPkg::lastParamIdx)
        addrActive <= 1'b0;
    end
  end

  // Data side runs on its own, so several addresses may be in flight.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      dataActive <= 1'b0;
      dataIdx <= '0;
      paramsDone <= 1'b0;
    end
    else
    begin
      paramsDone <= 1'b0;
      if (fetchStart)
      begin
        dataActive <= 1'b1;
        dataIdx <= '0;
      end
      else if (dataActive && paramDataReady)
      begin
        dataIdx <= dataIdx + 1'b1;
        if (dataIdx == kernelPkg::lastParamIdx)
        begin
          dataActive <= 1'b0;
          paramsDone <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (dataActive && paramDataReady)
      words[dataIdx] <= paramDataData;
  end

  // Word slots follow the offset order, low halves first.
  always_comb
  begin
    params.memBaseAddr = {words[1], words[0]};
    params.memBlockLength = words[2];
    params.testCount = words[3];
    params.errResultAddr = {words[5], words[4]};
    params.dcountResultAddr = {words[7], words[6]};
  end

  // A stalled offset stays on the channel unchanged.
  assert property (@(posedge clk) disable iff (reset)
    paramAddrReady && paramAddrStop |=> paramAddrReady && $stable(paramAddrData));

endmodule

/* axiPkg.sv */
// AXI package with bus widths, the response enum and write channel structs.
package axiPkg;

  localparam int addrWidth = 64;
  localparam int dataWidth = 64;
  localparam int strbWidth = dataWidth / 8;

  // Fixed attributes of a single 64-bit write beat.
  localparam logic [7:0] writeLen = 8'd0;
  localparam logic [2:0] writeSize = 3'd3;
  localparam logic [3:0] writeCache = 4'd3;
  localparam logic [strbWidth-1:0] writeStrb = '1;

  typedef enum logic [1:0] {
    Okay, ExOkay, SlvErr, DecErr
  } axiResp_t;

  typedef struct packed {
    logic [addrWidth-1:0] addr;
    logic [7:0]           len;
    logic [2:0]           size;
    logic [3:0]           cache;
  } writeAddr_t;

  typedef struct packed {
    logic [dataWidth-1:0] data;
    logic [strbWidth-1:0] strb;
    logic                 last;
  } writeData_t;

endpackage

/* kernelPkg.sv */
// Kernel package with parameter offsets, the run state enum and configuration structs.
package kernelPkg;

  localparam int numParamWords = 8;
  localparam int paramIdxWidth = $clog2(numParamWords);
  localparam logic [paramIdxWidth-1:0] lastParamIdx = paramIdxWidth'(numParamWords - 1);

  // Parameter register offsets, index 0 is fetched first.
  localparam logic [numParamWords-1:0][31:0] paramOffsets = {
    32'h5C, 32'h58, 32'h54, 32'h50,
    32'h4C, 32'h48, 32'h44, 32'h40
  };

  // Run sequence of the kernel control FSM.
  typedef enum logic [3:0] {
    Reset, Idle, Fetch, SetConfig, GetStatus,
    WriteErr, WaitErr, WriteDcount, WaitDcount, Report
  } runState_t;

  typedef struct packed {
    logic [63:0] memBaseAddr;
    logic [31:0] memBlockLength;
    logic [31:0] testCount;
    logic [63:0] errResultAddr;
    logic [63:0] dcountResultAddr;
  } kernelParams_t;

  typedef struct packed {
    logic [63:0] memBaseAddr;
    logic [31:0] memBlockLength;
    logic [31:0] testCount;
  } testConfig_t;

  typedef struct packed {
    logic [31:0] errorCount;
    logic [63:0] dataCount;
  } testStatus_t;

endpackage
